/* ooo_core_pkg.sv */
`default_nettype none

package ooo_core_pkg;

    localparam int XLEN       = 32;                  // Data and PC width
    localparam int ILEN       = 32;                  // Instruction width
    localparam int ROB_DEPTH  = 16;                  // Reorder buffer entries
    localparam int TAG_W      = $clog2(ROB_DEPTH);   // Entry index width
    localparam int REG_W      = 5;                   // Architectural register index
    localparam int MUL_STAGES = 3;                   // Multiplier pipeline depth

    // RISC-V major opcodes handled by this back end
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ops
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // Register-immediate ops

    localparam logic [6:0] FUNCT7_MUL = 7'b0000001;  // M extension group
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;  // SUB selector

    typedef logic [XLEN-1:0]  xlen_t;                // Operand or result word
    typedef logic [ILEN-1:0]  inst_t;                // Raw instruction word
    typedef logic [TAG_W-1:0] rob_tag_t;             // Buffer slot index
    typedef logic [TAG_W:0]   rob_cnt_t;             // Occupancy 0 to ROB_DEPTH
    typedef logic [REG_W-1:0] reg_idx_t;             // rd / rs index

    typedef enum logic [2:0] {
        ADD,                                         // a + b
        SUB,                                         // a - b
        AND,                                         // Bitwise and
        OR,                                          // Bitwise or
        XOR,                                         // Bitwise xor
        SLT                                          // Signed less than
    } alu_op_t;

    // Life of one buffer slot
    typedef enum logic [1:0] {
        FREE,                                        // Unallocated
        BUSY,                                        // Waiting for writeback
        DONE                                         // Result present
    } entry_state_t;

endpackage

`default_nettype wire

/* rob_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Allocation bundle from decode into the buffer
interface dispatch_if;
    logic                     valid;                 // New entry this cycle
    ooo_core_pkg::rob_tag_t   tag;                   // Slot to allocate
    ooo_core_pkg::reg_idx_t   dest;                  // rd field
    logic                     reg_write;             // Low for x0
    logic                     exc;                   // Illegal instruction

    modport dec (output valid, tag, dest, reg_write, exc);
    modport rob (input  valid, tag, dest, reg_write, exc);
endinterface

// Tagged result from an execute unit
interface wb_if;
    logic                     valid;                 // Result strobe
    ooo_core_pkg::rob_tag_t   tag;                   // Owning slot
    ooo_core_pkg::xlen_t      value;                 // Computed result

    modport unit (output valid, tag, value);
    modport rob  (input  valid, tag, value);
endinterface

`default_nettype wire

/* inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  ooo_core_pkg::inst_t     inst,
    input  ooo_core_pkg::xlen_t     a,
    input  ooo_core_pkg::xlen_t     b,
    input  logic                    stall,
    dispatch_if.dec                 disp,
    output logic                    alu_valid,
    output ooo_core_pkg::alu_op_t   alu_op,
    output ooo_core_pkg::xlen_t     alu_a,
    output ooo_core_pkg::xlen_t     alu_b,
    output logic                    mul_valid,
    output ooo_core_pkg::xlen_t     mul_a,
    output ooo_core_pkg::xlen_t     mul_b,
    output ooo_core_pkg::rob_tag_t  issue_tag
);

    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    ooo_core_pkg::xlen_t      imm;                   // I-type immediate, sign extended
    logic                     is_op, is_imm;
    logic                     to_mul, to_alu, f3_ok, illegal;
    logic                     accept;
    ooo_core_pkg::alu_op_t    op_sel;
    ooo_core_pkg::rob_tag_t   tail;                  // Next slot to hand out

    logic                     disp_vld_q;
    ooo_core_pkg::rob_tag_t   tag_q;
    ooo_core_pkg::reg_idx_t   dest_q;
    logic                     rw_q, exc_q;
    ooo_core_pkg::xlen_t      opa_q, opb_q;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm    = {{20{inst[31]}}, inst[31:20]};
    assign is_op  = (opcode == ooo_core_pkg::OPC_OP);
    assign is_imm = (opcode == ooo_core_pkg::OPC_OP_IMM);

    always_comb begin
        f3_ok  = 1'b1;
        op_sel = ooo_core_pkg::ADD;
        case (funct3)
            3'b000: op_sel = (is_op && funct7 == ooo_core_pkg::FUNCT7_ALT) ?
                             ooo_core_pkg::SUB : ooo_core_pkg::ADD;  // No SUBI form
            3'b010: op_sel = ooo_core_pkg::SLT;
            3'b100: op_sel = ooo_core_pkg::XOR;
            3'b110: op_sel = ooo_core_pkg::OR;
            3'b111: op_sel = ooo_core_pkg::AND;
            default: f3_ok = 1'b0;                   // Shifts and SLTU not built
        endcase
    end

    assign to_mul  = is_op && (funct7 == ooo_core_pkg::FUNCT7_MUL);
    assign to_alu  = ((is_op && !to_mul) || is_imm) && f3_ok;
    assign illegal = !to_mul && !to_alu;             // Goes to the buffer only
    assign accept  = (inst != '0) && !stall && !flush;  // Bubbles never allocate

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail       <= '0;
            disp_vld_q <= 1'b0;
            alu_valid  <= 1'b0;
            mul_valid  <= 1'b0;
        end else begin
            disp_vld_q <= accept;
            alu_valid  <= accept && to_alu;
            mul_valid  <= accept && to_mul;
            if (accept) begin
                tail <= tail + 1'b1;                 // Wraps with the buffer
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q  <= tail;
            dest_q <= inst[11:7];
            rw_q   <= (inst[11:7] != '0);            // x0 is never written
            exc_q  <= illegal;
            alu_op <= op_sel;
            opa_q  <= a;
            opb_q  <= is_imm ? imm : b;              // Immediate replaces rs2
        end
    end

    assign disp.valid     = disp_vld_q;
    assign disp.tag       = tag_q;
    assign disp.dest      = dest_q;
    assign disp.reg_write = rw_q;
    assign disp.exc       = exc_q;

    assign issue_tag = tag_q;                        // Same slot for either unit
    assign alu_a     = opa_q;
    assign alu_b     = opb_q;
    assign mul_a     = opa_q;
    assign mul_b     = opb_q;

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  ooo_core_pkg::alu_op_t   op,
    input  ooo_core_pkg::rob_tag_t  tag,
    input  ooo_core_pkg::xlen_t     a,
    input  ooo_core_pkg::xlen_t     b,
    wb_if.unit                      wb
);

    ooo_core_pkg::xlen_t     result;
    ooo_core_pkg::xlen_t     value_q;
    ooo_core_pkg::rob_tag_t  tag_q;
    logic                    valid_q;

    always_comb begin
        result = '0;
        case (op)
            ooo_core_pkg::ADD: result = a + b;
            ooo_core_pkg::SUB: result = a - b;
            ooo_core_pkg::AND: result = a & b;
            ooo_core_pkg::OR:  result = a | b;
            ooo_core_pkg::XOR: result = a ^ b;
            ooo_core_pkg::SLT: result[0] = ($signed(a) < $signed(b));  // 0 or 1
            default:           result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= 1'b0;                         // Drop the in-flight result
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            value_q <= result;
            tag_q   <= tag;
        end
    end

    assign wb.valid = valid_q;
    assign wb.tag   = tag_q;
    assign wb.value = value_q;

endmodule

`default_nettype wire

/* mul_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    in_valid,
    input  ooo_core_pkg::rob_tag_t  tag,
    input  ooo_core_pkg::xlen_t     a,
    input  ooo_core_pkg::xlen_t     b,
    wb_if.unit                      wb
);

    localparam int STG = ooo_core_pkg::MUL_STAGES;

    logic [STG-1:0]          vld;                    // One valid per stage
    ooo_core_pkg::rob_tag_t  tag_q [STG];            // Tag follows its operands

    ooo_core_pkg::xlen_t     ll_full, lh_full, hl_full;
    ooo_core_pkg::xlen_t     s1_ll;                  // Low x low
    logic [15:0]             s1_lh, s1_hl;           // Cross terms, low half only
    ooo_core_pkg::xlen_t     s2_ll;
    logic [15:0]             s2_cross;               // Summed cross terms
    ooo_core_pkg::xlen_t     s3_prod;                // Low word of a * b

    // 16x16 partial products, high x high never reaches the low word
    assign ll_full = a[15:0]  * b[15:0];
    assign lh_full = a[15:0]  * b[31:16];
    assign hl_full = a[31:16] * b[15:0];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            vld <= '0;                               // Kill every stage
        end else begin
            vld <= {vld[STG-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= tag;
        for (int i = 1; i < STG; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
        s1_ll    <= ll_full;                         // Stage 1
        s1_lh    <= lh_full[15:0];
        s1_hl    <= hl_full[15:0];
        s2_ll    <= s1_ll;                           // Stage 2
        s2_cross <= s1_lh + s1_hl;                   // Carry out is above bit 31
        s3_prod  <= s2_ll + {s2_cross, 16'h0000};    // Stage 3
    end

    assign wb.valid = vld[STG-1];
    assign wb.tag   = tag_q[STG-1];
    assign wb.value = s3_prod;

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                    clk,
    input  logic                    rst,
    dispatch_if.rob                 disp,
    wb_if.rob                       alu_wb,
    wb_if.rob                       mul_wb,
    output logic                    commit_valid,
    output ooo_core_pkg::reg_idx_t  commit_dest,
    output ooo_core_pkg::xlen_t     commit_value,
    output logic                    commit_reg_write,
    output logic                    exception_sig,
    output logic                    flush,
    output logic                    stall
);

    localparam int DEPTH = ooo_core_pkg::ROB_DEPTH;

    ooo_core_pkg::entry_state_t  state   [DEPTH];    // Per-slot FSM
    logic                        exc_q   [DEPTH];
    ooo_core_pkg::reg_idx_t      dest_q  [DEPTH];
    logic                        rw_q    [DEPTH];
    ooo_core_pkg::xlen_t         value_q [DEPTH];

    ooo_core_pkg::rob_tag_t      head;               // Oldest live slot
    ooo_core_pkg::rob_cnt_t      count;              // Non-FREE slots
    ooo_core_pkg::rob_cnt_t      count_next;

    logic alloc;
    logic alu_done, mul_done;
    logic head_done, head_exc, do_commit;

    // Everything arriving in the flush cycle is stale
    assign alloc    = disp.valid && !flush;
    assign alu_done = alu_wb.valid && !flush;
    assign mul_done = mul_wb.valid && !flush;

    assign head_done = (state[head] == ooo_core_pkg::DONE);
    assign head_exc  = head_done && exc_q[head];     // Retire as exception
    assign do_commit = head_done && !exc_q[head];    // Normal in-order retire

    always_comb begin
        count_next = count;
        if (alloc) begin
            count_next = count_next + 1'b1;
        end
        if (do_commit) begin
            count_next = count_next - 1'b1;
        end
    end

    // Room must remain for the entry already sitting on dispatch
    assign stall = (count + ooo_core_pkg::rob_cnt_t'(disp.valid))
                   >= ooo_core_pkg::rob_cnt_t'(DEPTH);

    always_ff @(posedge clk) begin
        if (rst) begin
            head          <= '0;
            count         <= '0;
            commit_valid  <= 1'b0;
            exception_sig <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= ooo_core_pkg::FREE;
            end
        end else if (head_exc) begin
            head          <= '0;                     // Decode rewinds tail on flush
            count         <= '0;
            commit_valid  <= 1'b0;
            exception_sig <= 1'b1;
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= ooo_core_pkg::FREE;      // Younger work discarded
            end
        end else begin
            commit_valid  <= do_commit;
            exception_sig <= 1'b0;
            count         <= count_next;
            if (alloc) begin
                state[disp.tag] <= disp.exc ? ooo_core_pkg::DONE : ooo_core_pkg::BUSY;
            end
            if (alu_done) begin
                state[alu_wb.tag] <= ooo_core_pkg::DONE;
            end
            if (mul_done) begin
                state[mul_wb.tag] <= ooo_core_pkg::DONE;  // Tags differ from ALU
            end
            if (do_commit) begin
                state[head] <= ooo_core_pkg::FREE;
                head        <= head + 1'b1;
            end
        end
    end

    // Slot payload and commit data
    always_ff @(posedge clk) begin
        if (alloc) begin
            exc_q[disp.tag]  <= disp.exc;
            dest_q[disp.tag] <= disp.dest;
            rw_q[disp.tag]   <= disp.reg_write;
        end
        if (alu_done) begin
            value_q[alu_wb.tag] <= alu_wb.value;
        end
        if (mul_done) begin
            value_q[mul_wb.tag] <= mul_wb.value;
        end
        if (do_commit) begin
            commit_dest      <= dest_q[head];
            commit_value     <= value_q[head];
            commit_reg_write <= rw_q[head];
        end
    end

    assign flush = exception_sig;                    // One cycle, same as the pulse

endmodule

`default_nettype wire

/* ooo_backend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_top (
    input  logic                    clk,
    input  logic                    rst,
    input  ooo_core_pkg::inst_t     inst,
    input  ooo_core_pkg::xlen_t     pc,              // Kept for port compatibility
    input  ooo_core_pkg::xlen_t     src_a,
    input  ooo_core_pkg::xlen_t     src_b,
    output logic                    stall,
    output logic                    commit_valid,
    output ooo_core_pkg::reg_idx_t  commit_dest,
    output ooo_core_pkg::xlen_t     commit_value,
    output logic                    commit_reg_write,
    output logic                    exception_sig
);

    logic                    flush;
    logic                    alu_valid, mul_valid;
    ooo_core_pkg::alu_op_t   alu_op;
    ooo_core_pkg::xlen_t     alu_a, alu_b;
    ooo_core_pkg::xlen_t     mul_a, mul_b;
    ooo_core_pkg::rob_tag_t  issue_tag;

    dispatch_if disp_bus ();
    wb_if       alu_wb_bus ();
    wb_if       mul_wb_bus ();

    inst_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .inst      (inst),
        .a         (src_a),
        .b         (src_b),
        .stall     (stall),
        .disp      (disp_bus.dec),
        .alu_valid (alu_valid),
        .alu_op    (alu_op),
        .alu_a     (alu_a),
        .alu_b     (alu_b),
        .mul_valid (mul_valid),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .issue_tag (issue_tag)
    );

    alu_unit u_alu (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .in_valid (alu_valid),
        .op       (alu_op),
        .tag      (issue_tag),
        .a        (alu_a),
        .b        (alu_b),
        .wb       (alu_wb_bus.unit)
    );

    mul_unit u_mul (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .in_valid (mul_valid),
        .tag      (issue_tag),
        .a        (mul_a),
        .b        (mul_b),
        .wb       (mul_wb_bus.unit)
    );

    reorder_buffer u_rob (
        .clk              (clk),
        .rst              (rst),
        .disp             (disp_bus.rob),
        .alu_wb           (alu_wb_bus.rob),
        .mul_wb           (mul_wb_bus.rob),
        .commit_valid     (commit_valid),
        .commit_dest      (commit_dest),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write),
        .exception_sig    (exception_sig),
        .flush            (flush),
        .stall            (stall)
    );

endmodule

`default_nettype wire

/* ooo_backend_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_protocol_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        commit_valid,
    input logic                        exception_sig,
    input logic                        stall,
    input logic                        alloc,
    input ooo_core_pkg::rob_cnt_t      count,
    input logic                        alu_done,
    input logic                        mul_done,
    input ooo_core_pkg::entry_state_t  alu_tgt_state,
    input ooo_core_pkg::entry_state_t  mul_tgt_state
);

    localparam ooo_core_pkg::rob_cnt_t DEPTH =
        ooo_core_pkg::rob_cnt_t'(ooo_core_pkg::ROB_DEPTH);

    a_retire_excl: assert property (@(posedge clk) disable iff (rst)
        !(commit_valid && exception_sig))
        else $error("commit_valid and exception_sig high together");

    a_alu_wb_live: assert property (@(posedge clk) disable iff (rst)
        alu_done |-> alu_tgt_state != ooo_core_pkg::FREE)
        else $error("ALU writeback into a FREE entry");

    a_mul_wb_live: assert property (@(posedge clk) disable iff (rst)
        mul_done |-> mul_tgt_state != ooo_core_pkg::FREE)
        else $error("multiplier writeback into a FREE entry");

    // Full buffer never takes another entry
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        alloc |-> count < DEPTH)
        else $error("allocation into a full buffer");

    a_stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall |=> !alloc)
        else $error("dispatch accepted while stall was high");

endmodule

bind reorder_buffer rob_protocol_checker u_rob_checker (
    .clk           (clk),
    .rst           (rst),
    .commit_valid  (commit_valid),
    .exception_sig (exception_sig),
    .stall         (stall),
    .alloc         (alloc),
    .count         (count),
    .alu_done      (alu_done),
    .mul_done      (mul_done),
    .alu_tgt_state (state[alu_wb.tag]),
    .mul_tgt_state (state[mul_wb.tag])
);

`default_nettype wire

/* tb_ooo_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_backend;

    localparam int NUM_REC    = 37;                  // Records in the pattern file
    localparam int REC_WORDS  = 5;                   // inst, a, b, expected, flags
    localparam int MAX_CYCLES = NUM_REC * 8 + 200;   // Run limit in clock cycles
    localparam int DRAIN      = 10;                  // Quiet cycles after the last retire

    logic                    clk;
    logic                    rst;
    ooo_core_pkg::inst_t     inst;
    ooo_core_pkg::xlen_t     pc;
    ooo_core_pkg::xlen_t     src_a;
    ooo_core_pkg::xlen_t     src_b;
    logic                    stall;
    logic                    commit_valid;
    ooo_core_pkg::reg_idx_t  commit_dest;
    ooo_core_pkg::xlen_t     commit_value;
    logic                    commit_reg_write;
    logic                    exception_sig;

    logic [31:0] pat_mem [NUM_REC*REC_WORDS];        // Flags: [4:0] rd, [8] wr, [12] exc
    int          exp_q [$];                          // Accepted record indices, oldest first
    logic [31:0] rng;
    int          rec_idx;                            // Next record to present
    int          gap;                                // Bubbles still owed before it
    int          cycles;
    int          quiet;

    ooo_backend_top uut (
        .clk              (clk),
        .rst              (rst),
        .inst             (inst),
        .pc               (pc),
        .src_a            (src_a),
        .src_b            (src_b),
        .stall            (stall),
        .commit_valid     (commit_valid),
        .commit_dest      (commit_dest),
        .commit_value     (commit_value),
        .commit_reg_write (commit_reg_write),
        .exception_sig    (exception_sig)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;                           // 40 ns period

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Flag bit 16 asks for a back-to-back record
    function automatic int bubble_gap(input int idx);
        if (idx >= NUM_REC || pat_mem[idx*REC_WORDS+4][16]) begin
            return 0;
        end
        rng = xorshift32(rng);
        return int'(rng % 3);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input ooo_core_pkg::xlen_t exp,
                               input ooo_core_pkg::xlen_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run("result word mismatch");
        end
    endtask

    task automatic check_dest(input string name, input ooo_core_pkg::reg_idx_t exp,
                              input ooo_core_pkg::reg_idx_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            abort_run("destination register mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            abort_run("control bit mismatch");
        end
    endtask

    // Outputs are registered, so they are steady at the falling edge
    task automatic sample_outputs();
        int          idx;
        logic [31:0] flags;
        string       name;
        if (commit_valid && exception_sig) begin
            abort_run("commit and exception pulsed in the same cycle");
        end else if ((commit_valid || exception_sig) && exp_q.size() == 0) begin
            abort_run("retire seen with no accepted record outstanding");
        end else if (commit_valid || exception_sig) begin
            idx   = exp_q.pop_front();
            flags = pat_mem[idx*REC_WORDS+4];
            name  = $sformatf("record %0d", idx);
            check_flag({name, " exception"}, flags[12], exception_sig);
            if (commit_valid) begin
                check_value({name, " value"}, pat_mem[idx*REC_WORDS+3], commit_value);
                check_dest({name, " dest"}, flags[4:0], commit_dest);
                check_flag({name, " reg_write"}, flags[8], commit_reg_write);
            end else begin
                exp_q.delete();                      // Younger work dies with the flush
            end
        end
        // Each accepted record not yet retired holds a slot or sits on dispatch
        check_flag($sformatf("cycle %0d stall", cycles),
                   exp_q.size() >= ooo_core_pkg::ROB_DEPTH, stall);
    endtask

    // Held while stalled or flushing, taken at the next rising edge otherwise
    task automatic drive_input();
        int base;
        if (rec_idx >= NUM_REC || gap > 0) begin
            inst  = '0;
            src_a = '0;
            src_b = '0;
            if (gap > 0) begin
                gap--;
            end
        end else begin
            base  = rec_idx * REC_WORDS;
            inst  = pat_mem[base];
            src_a = pat_mem[base+1];
            src_b = pat_mem[base+2];
            pc    = ooo_core_pkg::xlen_t'(rec_idx * 4);
            if (inst == '0 || (!stall && !exception_sig)) begin
                if (inst != '0) begin
                    exp_q.push_back(rec_idx);
                end
                rec_idx++;
                gap = bubble_gap(rec_idx);
            end
        end
    endtask

    initial begin
        rst         = 1'b1;
        inst        = '0;
        pc          = '0;
        src_a       = '0;
        src_b       = '0;
        rng         = 32'h4cfa_2728;
        rec_idx     = 0;
        cycles      = 0;
        quiet       = 0;
        $readmemh("rob_patterns.txt", pat_mem);
        gap = bubble_gap(0);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (quiet < DRAIN) begin
            @(negedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_run("timeout: commits stopped before all patterns retired");
            end else begin
                sample_outputs();
                drive_input();
                if (rec_idx >= NUM_REC && exp_q.size() == 0) begin
                    quiet++;                         // Any late retire fails above
                end
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* rob_patterns.txt */
// inst     src_a    src_b    expected flags
// flags: [4:0] rd, [8] reg_write, [12] exception, [16] no bubble before this record
000000B3 00001234 00000F0F 00002143 00000101
02000433 00012345 00000100 01234500 00000108
40000133 00000010 00000030 FFFFFFE0 00010102
000071B3 F0F0F0F0 0FF00FF0 00F000F0 00010103
00006233 12340000 00005678 12345678 00000104
02000433 FFFFFFFF 00000003 FFFFFFFD 00000108
000042B3 FFFF0000 0F0F0F0F F0F00F0F 00000105
00002333 FFFFFFFF 00000001 00000001 00000106
FFB00393 00000010 DEADBEEF 0000000B 00000107
00000033 00000005 00000006 0000000B 00000000
00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000
00000483 00000000 00000000 00000000 00001109
00000533 00000100 00000200 00000300 0001010A
000045B3 000000FF 0000000F 000000F0 0001010B
000000B3 00000001 00000002 00000003 00010101
02000633 01010101 00000001 01010101 0000010C
020006B3 01010101 00000002 02020202 0001010D
02000733 01010101 00000003 03030303 0001010E
020007B3 01010101 00000004 04040404 0001010F
02000833 01010101 00000005 05050505 00010110
020008B3 01010101 00000006 06060606 00010111
02000933 01010101 00000007 07070707 00010112
020009B3 01010101 00000008 08080808 00010113
02000A33 01010101 00000009 09090909 00010114
02000AB3 01010101 0000000A 0A0A0A0A 00010115
02000B33 01010101 0000000B 0B0B0B0B 00010116
02000BB3 01010101 0000000C 0C0C0C0C 00010117
02000C33 01010101 0000000D 0D0D0D0D 00010118
02000CB3 01010101 0000000E 0E0E0E0E 00010119
02000D33 01010101 0000000F 0F0F0F0F 0001011A
02000DB3 01010101 00000010 10101010 0001011B
02000E33 01010101 00000011 11111111 0001011C
02000EB3 01010101 00000012 12121212 0001011D
02000F33 01010101 00000013 13131313 0001011E
02000FB3 01010101 00000014 14141414 0001011F

/* files.f */
ooo_core_pkg.sv
rob_if.sv
inst_decode.sv
alu_unit.sv
mul_unit.sv
reorder_buffer.sv
ooo_backend_top.sv
ooo_backend_sva.sv
tb_ooo_backend.sv

/* Makefile */
TOP = tb_ooo_backend

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
